//--- build.f
+incdir+common
common/rms_pkg.sv
common/rms_ctrl_if.sv
rtl/rms_int_to_bf16.sv
rtl/rms_lane_convert.sv
rms_square_sum/rms_square_sum.sv
rms_vector_buffer/rms_vector_buffer.sv
rtl/rms_norm_front.sv
sim/rms_norm_front_assert.sv
sim/tb_rms_norm_front.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the RMS-norm front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rms_norm_front -f build.f -o tb_rms_norm_front

status=0
./obj_dir/tb_rms_norm_front > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation finished cleanly"

//--- sim/tb_rms_norm_front.sv
/*
 * Testbench for the RMS-norm front end
 * Table-driven vectors with a reference model for conversion,
 * square sum, gamma pass-through and replay framing
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rms_norm_front import rms_pkg::*; ();

  localparam int NVEC = 7;
  localparam int MAXE = 68;

  // Vector table of length, reduction count, scale position and random data flag
  localparam int TBL_NUM   [NVEC] = '{16, 14, 13, 20, 9, 64, 12};
  localparam int TBL_K     [NVEC] = '{16, 14, 6, 20, 3, 40, 5};
  localparam int TBL_SCALE [NVEC] = '{0, 3, -2, 0, 3, -2, -2};
  localparam bit TBL_RND   [NVEC] = '{0, 0, 1, 1, 1, 1, 0};

  // Fixed lanes with both extremes, zeros and mixed signs
  localparam int PATTERN [12] = '{0, 127, -128, -1, 1, -5, 37, -64, 100, -99, 2, 0};

  logic       clk = 1'b0;
  logic       rst_n;
  cnt_t       data_num;
  logic       data_num_vld;
  cnt_t       k;
  logic       k_vld;
  scale_t     in_scale_pos;
  logic       in_scale_pos_vld;
  fix_vec_t   fixed_data;
  lane_mask_t fixed_data_vld;
  bf_vec_t    gamma;
  lane_mask_t gamma_vld;
  bf16_t      sq_sum;
  logic       sq_sum_vld;
  bf_vec_t    out_x;
  bf_vec_t    out_gamma;
  lane_mask_t out_vld;
  logic       out_last;

  // Reference data per vector
  int          act       [NVEC][MAXE];
  logic [15:0] gam       [NVEC][MAXE];
  logic [15:0] exp_sum   [NVEC];
  int          n_beats   [NVEC];
  bit          sq_seen   [NVEC];
  bit          last_seen [NVEC];

  int mon_v = 0;
  int mon_beat = 0;
  int sq_cnt = 0;
  int cycle_cnt = 0;
  int timeout_cycles = 100000;

  rms_norm_front u_rms_norm_front (
    .clk              (clk),
    .rst_n            (rst_n),
    .data_num         (data_num),
    .data_num_vld     (data_num_vld),
    .k                (k),
    .k_vld            (k_vld),
    .in_scale_pos     (in_scale_pos),
    .in_scale_pos_vld (in_scale_pos_vld),
    .fixed_data       (fixed_data),
    .fixed_data_vld   (fixed_data_vld),
    .gamma            (gamma),
    .gamma_vld        (gamma_vld),
    .sq_sum           (sq_sum),
    .sq_sum_vld       (sq_sum_vld),
    .out_x            (out_x),
    .out_gamma        (out_gamma),
    .out_vld          (out_vld),
    .out_last         (out_last)
  );

  always #2 clk = ~clk;

  // --------------------
  // Reference model
  function automatic logic [15:0] to_bf16(input int value, input int scale);
    int         mag;
    int         e;
    logic       sgn;
    logic [6:0] frac;
    logic [7:0] ex;
    if (value == 0)
      return 16'h0000;
    sgn = (value < 0);
    mag = sgn ? -value : value;
    e = 0;
    while ((mag >> (e + 1)) != 0)
      e++;
    if (e >= 7)
      frac = 7'((mag >> (e - 7)) & 127);
    else
      frac = 7'((mag << (7 - e)) & 127);
    // Exponent wraps modulo 256
    ex = 8'((127 + e - scale) & 255);
    return {sgn, ex, frac};
  endfunction

  function automatic lane_mask_t beat_mask(input int v, input int b);
    int rem;
    rem = TBL_NUM[v] - 4 * b;
    if (rem >= 4)
      return 4'hf;
    return lane_mask_t'((1 << rem) - 1);
  endfunction

  function automatic int random_lane();
    logic signed [7:0] r;
    r = 8'($urandom);
    return int'(r);
  endfunction

  task automatic build_expected();
    int         cnt;
    int         s;
    lane_mask_t m;
    for (int v = 0; v < NVEC; v++) begin
      for (int i = 0; i < MAXE; i++) begin
        if (TBL_RND[v]) begin
          act[v][i] = random_lane();
          gam[v][i] = 16'($urandom);
        end else begin
          act[v][i] = PATTERN[(i + v) % 12];
          gam[v][i] = 16'((v << 12) + i * 16'h0123 + 16'h0011);
        end
      end
      n_beats[v] = (TBL_NUM[v] + 3) / 4;
      // Whole beats are summed until k elements are counted
      cnt = 0;
      s = 0;
      for (int b = 0; b < n_beats[v]; b++) begin
        if (cnt < TBL_K[v]) begin
          m = beat_mask(v, b);
          for (int l = 0; l < 4; l++) begin
            if (m[l]) begin
              s += act[v][4*b+l] * act[v][4*b+l];
              cnt++;
            end
          end
        end
      end
      exp_sum[v] = to_bf16(s, TBL_SCALE[v]);
    end
  endtask

  // --------------------
  // Checking
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected)
      stop_with_failure($sformatf("ERROR %s: got 0x%0h, expected 0x%0h",
                                  name, actual, expected));
  endtask

  task automatic check_replay_beat(input int v, input int b);
    lane_mask_t m;
    if (b >= n_beats[v])
      stop_with_failure($sformatf("Vector %0d replayed more beats than expected", v));
    m = beat_mask(v, b);
    check_val("out_vld", out_vld, m);
    check_val("out_last", out_last, b == n_beats[v] - 1);
    for (int l = 0; l < 4; l++) begin
      if (m[l]) begin
        check_val($sformatf("out_x[%0d]", l), out_x[16*l +: 16],
                  to_bf16(act[v][4*b+l], TBL_SCALE[v]));
        check_val($sformatf("out_gamma[%0d]", l), out_gamma[16*l +: 16], gam[v][4*b+l]);
      end
    end
  endtask

  // Outputs are sampled on the falling edge away from the driving edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (sq_sum_vld) begin
        sq_cnt = sq_cnt + 1;
        if (mon_v < NVEC) begin
          check_val("sq_sum_vld pulses", sq_cnt, 1);
          check_val("sq_sum", sq_sum, exp_sum[mon_v]);
          sq_seen[mon_v] = 1'b1;
        end
      end
      if (out_vld != '0 && mon_v >= NVEC) begin
        stop_with_failure("A replay beat came out after the last vector");
      end else if (out_vld != '0) begin
        check_val("sq_sum_vld before replay", sq_cnt, 1);
        check_replay_beat(mon_v, mon_beat);
        mon_beat = mon_beat + 1;
        if (out_last) begin
          last_seen[mon_v] = 1'b1;
          mon_v = mon_v + 1;
          mon_beat = 0;
          sq_cnt = 0;
        end
      end else if (out_last) begin
        stop_with_failure("out_last was raised without a valid replay beat");
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > timeout_cycles)
      stop_with_failure($sformatf("Timeout after %0d cycles, vectors did not complete",
                                  cycle_cnt));
  end

  // --------------------
  // Stimulus
  task automatic load_config(input int v);
    k                <= cnt_t'(TBL_K[v]);
    k_vld            <= 1'b1;
    in_scale_pos     <= scale_t'(TBL_SCALE[v]);
    in_scale_pos_vld <= 1'b1;
    @(posedge clk);
    k_vld            <= 1'b0;
    in_scale_pos_vld <= 1'b0;
  endtask

  // Beats go out back to back; data_num rides with the first one
  task automatic drive_vector(input int v);
    fix_vec_t fd;
    bf_vec_t  gd;
    for (int b = 0; b < n_beats[v]; b++) begin
      if (b > 0)
        @(posedge clk);
      for (int l = 0; l < 4; l++) begin
        fd[8*l +: 8]  = 8'(act[v][4*b+l]);
        gd[16*l +: 16] = gam[v][4*b+l];
      end
      fixed_data     <= fd;
      gamma          <= gd;
      fixed_data_vld <= beat_mask(v, b);
      gamma_vld      <= beat_mask(v, b);
      data_num       <= cnt_t'(TBL_NUM[v]);
      data_num_vld   <= (b == 0);
    end
    @(posedge clk);
    fixed_data_vld <= '0;
    gamma_vld      <= '0;
    data_num_vld   <= 1'b0;
  endtask

  initial begin
    rst_n            = 1'b0;
    data_num         = '0;
    data_num_vld     = 1'b0;
    k                = '0;
    k_vld            = 1'b0;
    in_scale_pos     = '0;
    in_scale_pos_vld = 1'b0;
    fixed_data       = '0;
    fixed_data_vld   = '0;
    gamma            = '0;
    gamma_vld        = '0;
    void'($urandom(63404));
    build_expected();
    timeout_cycles = 64;
    for (int v = 0; v < NVEC; v++)
      timeout_cycles += 2 * n_beats[v] + 16;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    load_config(0);
    repeat (2) @(posedge clk);

    for (int v = 0; v < NVEC; v++) begin
      drive_vector(v);
      // Next k and scale load once the sum is out while data_num waits for the beats
      if (v + 1 < NVEC) begin
        while (!sq_seen[v])
          @(posedge clk);
        load_config(v + 1);
      end
      while (!last_seen[v])
        @(posedge clk);
    end

    repeat (4) @(posedge clk);
    if (sq_cnt == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_with_failure("A square sum strobe came out after the last vector");
    end
  end

endmodule

`default_nettype wire

//--- sim/rms_norm_front_assert.sv
/*
 * Protocol checks for the RMS-norm front end
 * Bound to the top level ports
 */
`timescale 1ns/1ps
`default_nettype none

module rms_norm_front_assert import rms_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       sq_sum_vld,
  input lane_mask_t out_vld,
  input logic       out_last
);

  // Square sum strobe is a single-cycle pulse
  a_sq_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    sq_sum_vld |=> !sq_sum_vld)
    else $error("sq_sum_vld held for more than one cycle");

  a_last_vld: assert property (@(posedge clk) disable iff (!rst_n)
    out_last |-> (out_vld != '0))
    else $error("out_last raised with no valid lanes");

  // Outputs stay quiet while reset is held
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> (!sq_sum_vld && (out_vld == '0) && !out_last))
    else $error("output active during reset");

endmodule

bind rms_norm_front rms_norm_front_assert u_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .sq_sum_vld (sq_sum_vld),
  .out_vld    (out_vld),
  .out_last   (out_last)
);

`default_nettype wire

//--- rtl/rms_norm_front.sv
/*
 * RMS-norm front end top level
 * Configuration registers, int8 to bfloat16 conversion, square sum
 * and activation/gamma replay buffer
 */
`timescale 1ns/1ps
`default_nettype none

module rms_norm_front import rms_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  cnt_t       data_num,
  input  logic       data_num_vld,
  input  cnt_t       k,
  input  logic       k_vld,
  input  scale_t     in_scale_pos,
  input  logic       in_scale_pos_vld,
  input  fix_vec_t   fixed_data,
  input  lane_mask_t fixed_data_vld,
  input  bf_vec_t    gamma,
  input  lane_mask_t gamma_vld,
  output bf16_t      sq_sum,
  output logic       sq_sum_vld,
  output bf_vec_t    out_x,
  output bf_vec_t    out_gamma,
  output lane_mask_t out_vld,
  output logic       out_last
);

  rms_ctrl_if ctrl ();

  bf_vec_t    x_bf;
  lane_mask_t x_vld;

  // --------------------
  // Configuration registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl.data_num     <= '0;
      ctrl.k            <= '0;
      ctrl.in_scale_pos <= '0;
    end else begin
      if (data_num_vld)
        ctrl.data_num <= data_num;
      if (k_vld)
        ctrl.k <= k;
      if (in_scale_pos_vld)
        ctrl.in_scale_pos <= in_scale_pos;
    end
  end

  // --------------------
  // Datapath blocks
  rms_lane_convert u_lane_convert (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl           (ctrl),
    .fixed_data     (fixed_data),
    .fixed_data_vld (fixed_data_vld),
    .x_bf           (x_bf),
    .x_vld          (x_vld)
  );

  rms_square_sum u_square_sum (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl           (ctrl),
    .fixed_data     (fixed_data),
    .fixed_data_vld (fixed_data_vld),
    .sq_sum         (sq_sum),
    .sq_sum_vld     (sq_sum_vld)
  );

  rms_vector_buffer u_vector_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .x_bf      (x_bf),
    .x_vld     (x_vld),
    .gamma     (gamma),
    .gamma_vld (gamma_vld),
    .out_x     (out_x),
    .out_gamma (out_gamma),
    .out_vld   (out_vld),
    .out_last  (out_last)
  );

endmodule

`default_nettype wire

//--- rms_vector_buffer/rms_vector_buffer.sv
/*
 * Activation and gamma replay buffer
 * Stores one vector slot by slot and replays it after the square sum,
 * marking the final beat with out_last
 */
`timescale 1ns/1ps
`default_nettype none

`include "rms_cfg.svh"

module rms_vector_buffer import rms_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  rms_ctrl_if.buffer   ctrl,
  input  bf_vec_t      x_bf,
  input  lane_mask_t   x_vld,
  input  bf_vec_t      gamma,
  input  lane_mask_t   gamma_vld,
  output bf_vec_t      out_x,
  output bf_vec_t      out_gamma,
  output lane_mask_t   out_vld,
  output logic         out_last
);

  bf_vec_t    x_mem    [`RMS_DEPTH];
  lane_mask_t mask_mem [`RMS_DEPTH];
  bf_vec_t    g_mem    [`RMS_DEPTH];

  slot_idx_t  x_wr_ptr;
  slot_idx_t  g_wr_ptr;
  slot_idx_t  x_rd_ptr;
  slot_idx_t  g_rd_ptr;
  cnt_t       rd_cnt;
  logic       rd_en;
  logic       rd_active;
  logic       final_beat;

  // --------------------
  // Write side
  always_ff @(posedge clk) begin
    if (|x_vld) begin
      x_mem[x_wr_ptr]    <= x_bf;
      mask_mem[x_wr_ptr] <= x_vld;
    end
    if (|gamma_vld)
      g_mem[g_wr_ptr] <= gamma;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_wr_ptr <= '0;
      g_wr_ptr <= '0;
    end else if (ctrl.vector_last) begin
      x_wr_ptr <= '0;
      g_wr_ptr <= '0;
    end else begin
      if (|x_vld)
        x_wr_ptr <= x_wr_ptr + slot_idx_t'(1);
      if (|gamma_vld)
        g_wr_ptr <= g_wr_ptr + slot_idx_t'(1);
    end
  end

  // --------------------
  // Replay side
  // sum_done starts the first beat directly so replay begins one cycle later
  assign rd_active  = ctrl.sum_done | rd_en;
  assign final_beat = (rd_cnt + cnt_t'(`RMS_LANES)) >= ctrl.data_num;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_en    <= 1'b0;
      rd_cnt   <= '0;
      x_rd_ptr <= '0;
      g_rd_ptr <= '0;
      out_vld  <= '0;
      out_last <= 1'b0;
    end else if (ctrl.vector_last) begin
      rd_en    <= 1'b0;
      rd_cnt   <= '0;
      x_rd_ptr <= '0;
      g_rd_ptr <= '0;
      out_vld  <= '0;
      out_last <= 1'b0;
    end else if (rd_active) begin
      rd_en    <= !final_beat;
      rd_cnt   <= rd_cnt + cnt_t'(`RMS_LANES);
      x_rd_ptr <= x_rd_ptr + slot_idx_t'(1);
      g_rd_ptr <= g_rd_ptr + slot_idx_t'(1);
      out_vld  <= mask_mem[x_rd_ptr];
      out_last <= final_beat;
    end else begin
      out_vld  <= '0;
      out_last <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_active) begin
      out_x     <= x_mem[x_rd_ptr];
      out_gamma <= g_mem[g_rd_ptr];
    end
  end

  assign ctrl.vector_last = out_last;

endmodule

`default_nettype wire

//--- rms_square_sum/rms_square_sum.sv
/*
 * Square sum of the int8 lanes
 * Accumulates whole beats until K elements are counted, then emits
 * the sum once as a scaled bfloat16 word
 */
`timescale 1ns/1ps
`default_nettype none

`include "rms_cfg.svh"

module rms_square_sum import rms_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  rms_ctrl_if.sum    ctrl,
  input  fix_vec_t   fixed_data,
  input  lane_mask_t fixed_data_vld,
  output bf16_t      sq_sum,
  output logic       sq_sum_vld
);

  sq_t        sq_q [`RMS_LANES];
  lane_mask_t sq_vld;
  logic       gated;
  sum_t       sum_q;
  sum_t       nxt_sum;
  cnt_t       cnt_q;
  cnt_t       nxt_cnt;
  bf16_t      sum_bf;

  // --------------------
  // Squaring stage
  for (genvar i = 0; i < `RMS_LANES; i++) begin : g_sq
    fix8_t lane;

    assign lane = fixed_data[i*`RMS_FIX_W +: `RMS_FIX_W];

    always_ff @(posedge clk) begin
      if (!gated)
        sq_q[i] <= lane * lane;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      sq_vld <= '0;
    else
      sq_vld <= gated ? '0 : fixed_data_vld;
  end

  // Blocks new squares once the sum is complete
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      gated <= 1'b0;
    else if (ctrl.vector_last)
      gated <= 1'b0;
    else if (ctrl.sum_done)
      gated <= 1'b1;
  end

  // --------------------
  // Accumulation stage
  always_comb begin
    nxt_sum = sum_q;
    nxt_cnt = cnt_q;
    for (int i = 0; i < `RMS_LANES; i++) begin
      if (sq_vld[i]) begin
        nxt_sum = nxt_sum + sum_t'($unsigned(sq_q[i]));
        nxt_cnt = nxt_cnt + cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q         <= '0;
      cnt_q         <= '0;
      ctrl.sum_done <= 1'b0;
    end else if (ctrl.vector_last) begin
      sum_q         <= '0;
      cnt_q         <= '0;
      ctrl.sum_done <= 1'b0;
    end else begin
      // Pulses once per vector as the count then stays at or above k
      ctrl.sum_done <= (|sq_vld) && (cnt_q < ctrl.k) && (nxt_cnt >= ctrl.k);
      if ((|sq_vld) && (cnt_q < ctrl.k)) begin
        sum_q <= nxt_sum;
        cnt_q <= nxt_cnt;
      end
    end
  end

  // --------------------
  // Float output
  rms_int_to_bf16 u_sum_i2bf (
    .a         (sum_q),
    .sign_mode (1'b0),
    .scale     (ctrl.in_scale_pos),
    .z         (sum_bf)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      sq_sum_vld <= 1'b0;
    else
      sq_sum_vld <= ctrl.sum_done;
  end

  always_ff @(posedge clk) begin
    if (ctrl.sum_done)
      sq_sum <= sum_bf;
  end

endmodule

`default_nettype wire

//--- rtl/rms_lane_convert.sv
/*
 * Per-lane int8 to scaled bfloat16 conversion
 * Result registered together with the lane valid mask
 */
`timescale 1ns/1ps
`default_nettype none

`include "rms_cfg.svh"

module rms_lane_convert import rms_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  rms_ctrl_if.conv   ctrl,
  input  fix_vec_t   fixed_data,
  input  lane_mask_t fixed_data_vld,
  output bf_vec_t    x_bf,
  output lane_mask_t x_vld
);

  bf_vec_t conv_bf;

  for (genvar i = 0; i < `RMS_LANES; i++) begin : g_lane
    fix8_t lane;

    assign lane = fixed_data[i*`RMS_FIX_W +: `RMS_FIX_W];

    rms_int_to_bf16 u_i2bf (
      .a         (sum_t'(lane)),
      .sign_mode (1'b1),
      .scale     (ctrl.in_scale_pos),
      .z         (conv_bf[i*`RMS_BF_W +: `RMS_BF_W])
    );
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      x_vld <= '0;
    else
      x_vld <= fixed_data_vld;
  end

  always_ff @(posedge clk) begin
    x_bf <= conv_bf;
  end

endmodule

`default_nettype wire

//--- rtl/rms_int_to_bf16.sv
/*
 * Integer to bfloat16 converter
 * Leading-zero count, truncated fraction, exponent offset by a scale position
 */
`timescale 1ns/1ps
`default_nettype none

`include "rms_cfg.svh"

module rms_int_to_bf16 import rms_pkg::*; (
  input  sum_t   a,
  input  logic   sign_mode,
  input  scale_t scale,
  output bf16_t  z
);

  localparam int LZ_W   = $clog2(`RMS_SUM_W);
  localparam int BIAS   = (1 << (`RMS_EXP_W - 1)) - 1;
  localparam int TOP_BIT = `RMS_SUM_W - 1;

  typedef logic [`RMS_EXP_W-1:0] exp_t;

  logic                 neg;
  sum_t                 mag;
  sum_t                 norm;
  logic [LZ_W-1:0]      lz;
  exp_t                 exp_field;
  logic [`RMS_MAN_W-1:0] frac;

  always_comb begin
    neg = sign_mode & a[TOP_BIT];
    mag = neg ? sum_t'(-a) : a;
    // Highest set bit wins
    lz = '0;
    for (int i = 0; i < `RMS_SUM_W; i++) begin
      if (mag[i])
        lz = LZ_W'(TOP_BIT - i);
    end
    norm = mag << lz;
    frac = norm[TOP_BIT-1 -: `RMS_MAN_W];
    // Exponent wraps modulo 256
    exp_field = exp_t'(BIAS + TOP_BIT - int'(lz)) - exp_t'(scale);
  end

  assign z = (mag == '0) ? '0 : {neg, exp_field, frac};

endmodule

`default_nettype wire

//--- common/rms_ctrl_if.sv
/*
 * RMS-norm control interface
 * Configuration plus the per-vector sum_done and vector_last events
 */
`timescale 1ns/1ps
`default_nettype none

interface rms_ctrl_if import rms_pkg::*; ();

  cnt_t   data_num;
  cnt_t   k;
  scale_t in_scale_pos;
  logic   sum_done;
  logic   vector_last;

  modport cfg    (output data_num, output k, output in_scale_pos);
  modport conv   (input in_scale_pos);
  modport sum    (input k, input in_scale_pos, input vector_last, output sum_done);
  modport buffer (input data_num, input sum_done, output vector_last);

endinterface

`default_nettype wire

//--- common/rms_pkg.sv
/*
 * RMS-norm front end types
 * Vector typedefs shared by the datapath blocks
 */
`default_nettype none

package rms_pkg;

  `include "rms_cfg.svh"

  // Scalars
  typedef logic signed [`RMS_FIX_W-1:0]   fix8_t;
  typedef logic        [`RMS_BF_W-1:0]    bf16_t;
  typedef logic signed [2*`RMS_FIX_W-1:0] sq_t;
  typedef logic        [`RMS_SUM_W-1:0]   sum_t;
  typedef logic        [`RMS_CNT_W-1:0]   cnt_t;
  typedef logic signed [`RMS_SCALE_W-1:0] scale_t;

  // Per-beat vectors with lane 0 in the low bits
  typedef logic [`RMS_LANES-1:0]            lane_mask_t;
  typedef logic [`RMS_LANES*`RMS_FIX_W-1:0] fix_vec_t;
  typedef logic [`RMS_LANES*`RMS_BF_W-1:0]  bf_vec_t;

  // Buffer slot address
  typedef logic [`RMS_SLOT_W-1:0] slot_idx_t;

endpackage

`default_nettype wire

//--- common/rms_cfg.svh
/*
 * RMS-norm front end configuration
 * Lane count, datapath widths, buffer depth and bfloat16 field sizes
 */
`ifndef RMS_CFG_SVH
`define RMS_CFG_SVH

// Lanes per beat and activation width
`define RMS_LANES   4
`define RMS_FIX_W   8

// bfloat16 word and its fields
`define RMS_BF_W    16
`define RMS_MAN_W   7
`define RMS_EXP_W   8

// Accumulator, length/count and scale position widths
`define RMS_SUM_W   24
`define RMS_CNT_W   10
`define RMS_SCALE_W 5

// Buffer slots for up to 64 elements plus one spare
`define RMS_DEPTH   17
`define RMS_SLOT_W  5

`endif
